// File: bench/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Architectural state of the reference model
logic [63:0] model_regs [32];
logic [63:0] model_pc;

// I-type, also used for JALR
function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [4:0] rd,
                                      input logic [2:0] f3, input logic [4:0] rs1,
                                      input logic [11:0] imm);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [4:0] rs2);
  return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
endfunction

function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
  return {imm, rd, `RV_OP_LUI};
endfunction

// Byte offset, bit 0 dropped by the format
function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
  return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
endfunction

// Executes one instruction on the model state
// data_ok low means an unsupported word, retired as a no-op
function automatic void model_step(input logic [31:0] inst, output logic [63:0] pc,
                                   output logic [4:0] rd, output logic [63:0] data,
                                   output logic we, output logic data_ok);
  logic [63:0] a;
  logic [63:0] b;
  logic [63:0] imm;
  logic [63:0] next_pc;
  a       = model_regs[inst[19:15]];
  b       = model_regs[inst[24:20]];
  imm     = {{52{inst[31]}}, inst[31:20]};
  next_pc = model_pc + 64'd4;
  pc      = model_pc;
  rd      = inst[11:7];
  data    = '0;
  data_ok = 1'b1;
  // Keyed on funct7, funct3, opcode
  casez ({inst[31:25], inst[14:12], inst[6:0]})
    {7'b???????, 3'b000, `RV_OP_IMM}: data = a + imm;
    {7'b0000000, 3'b000, `RV_OP_REG}: data = a + b;
    {7'b0100000, 3'b000, `RV_OP_REG}: data = a - b;
    {7'b0000000, 3'b100, `RV_OP_REG}: data = a ^ b;
    {7'b0000000, 3'b110, `RV_OP_REG}: data = a | b;
    {7'b0000000, 3'b111, `RV_OP_REG}: data = a & b;
    {7'b???????, 3'b???, `RV_OP_LUI}: data = {{32{inst[31]}}, inst[31:12], 12'h000};
    {7'b???????, 3'b???, `RV_OP_JAL}: begin
      data    = model_pc + 64'd4; // Link
      next_pc = model_pc + {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    end
    {7'b???????, 3'b000, `RV_OP_JALR}: begin
      data    = model_pc + 64'd4;
      next_pc = (a + imm) & ~64'd1; // Old rs1, bit 0 cleared
    end
    default: data_ok = 1'b0;
  endcase
  we = data_ok && (rd != 5'd0);
  if (we) model_regs[rd] = data;
  model_pc = next_pc;
endfunction

`endif

// File: bench/tb_rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_defs.svh"

module tb_rv_core_top;

  localparam int          check_count  = 200;
  localparam int          prog_len     = 64;
  localparam int          watchdog_ns  = check_count * 20 * 4; // Retirements x cycles x period
  localparam logic [63:0] entry_addr   = 64'h400;              // Fits a JALR immediate from x0
  localparam logic [63:0] stackptr_val = 64'h0000_7fff_fff0_0000;

  logic                   clk;
  logic                   reset;
  rv_core_pkg::xlen_t     entry;
  rv_core_pkg::xlen_t     stackptr;
  logic                   imem_ack;
  rv_core_pkg::inst_t     imem_data;
  logic                   imem_req;
  rv_core_pkg::xlen_t     imem_addr;
  logic                   retire_valid;
  rv_core_pkg::xlen_t     retire_pc;
  rv_core_pkg::reg_addr_t retire_rd;
  rv_core_pkg::xlen_t     retire_data;
  logic                   retire_we;

  integer      seed        = 38;
  int          error_count = 0;
  int          check_total = 0;
  int          retired     = 0;
  logic [31:0] prog_words [prog_len];
  logic        prev_req;       // Port values one edge back
  logic        prev_ack;
  logic [63:0] prev_addr;
  logic        first_req_seen;

  `include "tb_ref_model.svh"

  rv_core_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    check_total++;
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  function automatic int pick(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Program image surrounded by words of an unsupported opcode
  function automatic logic [31:0] fetch_word(input logic [63:0] addr);
    logic [63:0] offset;
    offset = addr - entry_addr;
    if (offset < 64'(prog_len * 4)) return prog_words[offset[7:2]];
    return {addr[24:0] ^ addr[49:25] ^ 25'(addr[63:50]), 7'b0001011};
  endfunction

  task automatic build_program();
    int         target;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    prog_words[0] = enc_i(`RV_OP_IMM, 5'd5, 3'd0, 5'd2, 12'd0); // x5 = sp
    prog_words[1] = enc_i(`RV_OP_IMM, 5'd0, 3'd0, 5'd5, 12'd7); // Write to x0 is dropped
    prog_words[2] = enc_r(7'd0, 3'd0, 5'd6, 5'd0, 5'd0);        // Reads x0 twice
    for (int i = 3; i < prog_len - 1; i++) begin
      target = pick(prog_len); // Jump destination as a word index
      rd     = 5'(pick(32));
      rs1    = 5'(pick(32));
      rs2    = 5'(pick(32));
      if (rd == 5'd2) rd = 5'd0; // Keeps sp intact and gives x0 more writes
      case (pick(11))
        0, 1: prog_words[i] = enc_i(`RV_OP_IMM, rd, 3'd0, rs1, 12'(pick(4096)));
        2: prog_words[i] = enc_r(7'b0000000, 3'b000, rd, rs1, rs2); // ADD
        3: prog_words[i] = enc_r(7'b0100000, 3'b000, rd, rs1, rs2); // SUB
        4: prog_words[i] = enc_r(7'b0000000, 3'b100, rd, rs1, rs2); // XOR
        5: prog_words[i] = enc_r(7'b0000000, 3'b110, rd, rs1, rs2); // OR
        6: prog_words[i] = enc_r(7'b0000000, 3'b111, rd, rs1, rs2); // AND
        7: prog_words[i] = enc_lui(rd, 20'(pick(1 << 20)));
        8: prog_words[i] = enc_jal(rd, 21'((target - i) * 4));
        9: prog_words[i] = enc_i(`RV_OP_JALR, rd, 3'd0, 5'd0,
                                 entry_addr[11:0] + 12'(target * 4 + pick(2))); // Odd sometimes
        default: begin
          if (pick(2) == 0) prog_words[i] = {25'($random(seed)), 7'b0000011}; // Load
          else prog_words[i] = enc_r(7'b0000000, 3'b001, rd, rs1, rs2);       // SLL
        end
      endcase
    end
    prog_words[prog_len - 1] = enc_jal(5'd0, 21'd0); // Self-loop
  endtask

  // Instruction memory side of the four-phase handshake
  initial begin : imem_responder
    int delay;
    imem_ack  <= 1'b0;
    imem_data <= '0;
    forever begin
      @(posedge clk);
      if (!reset && imem_req && !imem_ack) begin
        delay = pick(6);
        repeat (delay) @(posedge clk);
        imem_data <= fetch_word(imem_addr);
        imem_ack  <= 1'b1;
        do @(posedge clk); while (imem_req); // Ack held until req falls
        imem_ack <= 1'b0;
      end
    end
  end

  // Request rules on the instruction port
  always @(posedge clk) begin
    if (reset) begin
      prev_req       <= 1'b0;
      prev_ack       <= 1'b0;
      first_req_seen <= 1'b0;
    end else begin
      if (imem_req && !prev_req) begin
        check_value("imem_ack when imem_req rose", 64'(prev_ack), 64'd0);
        if (!first_req_seen) check_value("first imem_addr", imem_addr, entry_addr);
        first_req_seen <= 1'b1;
      end
      if (imem_req && prev_req) check_value("imem_addr during request", imem_addr, prev_addr);
      prev_req  <= imem_req;
      prev_ack  <= imem_ack;
      prev_addr <= imem_addr;
    end
  end

  // One model step per retirement
  always @(posedge clk) begin : compare_retire
    logic [63:0] exp_pc;
    logic [4:0]  exp_rd;
    logic [63:0] exp_data;
    logic        exp_we;
    logic        exp_ok;
    if (!reset && retire_valid && retired < check_count) begin
      model_step(fetch_word(model_pc), exp_pc, exp_rd, exp_data, exp_we, exp_ok);
      check_value("retire_pc", retire_pc, exp_pc); // Catches wrong-path retirements
      check_value("retire_we", 64'(retire_we), 64'(exp_we));
      if (exp_ok) begin
        check_value("retire_rd", 64'(retire_rd), 64'(exp_rd));
        check_value("retire_data", retire_data, exp_data);
      end
      if (exp_pc == entry_addr) check_value("x2 at entry", retire_data, stackptr_val);
      retired++;
    end
  end

  initial begin
    reset    <= 1'b1;
    entry    <= entry_addr;
    stackptr <= stackptr_val;
    build_program();
    foreach (model_regs[i]) model_regs[i] = (i == 2) ? stackptr_val : 64'd0;
    model_pc = entry_addr;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    check_value("imem_req after reset", 64'(imem_req), 64'd0);
    check_value("retire_valid after reset", 64'(retire_valid), 64'd0);
    while (retired < check_count) @(negedge clk);
    $display("Errors: %0d in %0d checks over %0d retirements", error_count, check_total, retired);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(watchdog_ns);
    $display("Timeout: only %0d of %0d instructions retired in %0d ns",
             retired, check_count, watchdog_ns);
    $display("Errors: %0d in %0d checks over %0d retirements", error_count, check_total, retired);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: design/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_defs.svh"

module execute_unit (
  input  wire                       clk,
  input  wire                       reset,
  input  wire  rv_core_pkg::xlen_t  stackptr,     // Forwarded to the register file
  input  wire  rv_core_pkg::xlen_t  head_pc,
  input  wire  rv_core_pkg::inst_t  head_inst,
  input  wire                       empty,
  output logic                      pop,
  output logic                      redirect,
  output rv_core_pkg::xlen_t        redirect_pc,
  output logic                      retire_valid,
  output rv_core_pkg::xlen_t        retire_pc,
  output rv_core_pkg::reg_addr_t    retire_rd,
  output rv_core_pkg::xlen_t        retire_data,
  output logic                      retire_we
);

  localparam int unsigned inst_bytes = `RV_ILEN / 8;

  rv_core_pkg::op_kind_t  op;
  rv_core_pkg::reg_addr_t rd;
  rv_core_pkg::reg_addr_t rs1;
  rv_core_pkg::reg_addr_t rs2;
  rv_core_pkg::xlen_t     imm;
  rv_core_pkg::xlen_t     src1;
  rv_core_pkg::xlen_t     src2;
  rv_core_pkg::xlen_t     result;
  rv_core_pkg::xlen_t     link_pc;  // Return address for jumps
  rv_core_pkg::xlen_t     jalr_sum;
  logic                   writes_rd;

  inst_decoder u_decoder (
    .inst      (head_inst),
    .op        (op),
    .rd        (rd),
    .rs1       (rs1),
    .rs2       (rs2),
    .imm       (imm),
    .writes_rd (writes_rd)
  );

  // Write-back lands in the same cycle as the read, so no hazard tracking
  register_file u_regs (
    .clk          (clk),
    .reset        (reset),
    .stackptr     (stackptr),
    .rs1          (rs1),
    .rs2          (rs2),
    .write_enable (pop && writes_rd),
    .write_addr   (rd),
    .write_data   (result),
    .read_data1   (src1),
    .read_data2   (src2)
  );

  assign pop      = !empty; // One instruction per cycle whenever available
  assign link_pc  = head_pc + rv_core_pkg::xlen_t'(inst_bytes);
  assign jalr_sum = src1 + imm;

  always_comb begin
    case (op)
      rv_core_pkg::OP_ADDI: result = src1 + imm;
      rv_core_pkg::OP_ADD:  result = src1 + src2;
      rv_core_pkg::OP_SUB:  result = src1 - src2;
      rv_core_pkg::OP_AND:  result = src1 & src2;
      rv_core_pkg::OP_OR:   result = src1 | src2;
      rv_core_pkg::OP_XOR:  result = src1 ^ src2;
      rv_core_pkg::OP_LUI:  result = imm;
      rv_core_pkg::OP_JAL,
      rv_core_pkg::OP_JALR: result = link_pc;
      default:              result = '0;
    endcase
  end

  // Jumps flush the queue and steer fetch
  assign redirect = pop && (op == rv_core_pkg::OP_JAL || op == rv_core_pkg::OP_JALR);
  assign redirect_pc = (op == rv_core_pkg::OP_JALR) ? {jalr_sum[`RV_XLEN-1:1], 1'b0}
                                                    : head_pc + imm;

  always_ff @(posedge clk) begin
    if (reset) begin
      retire_valid <= 1'b0;
      retire_we    <= 1'b0;
    end else begin
      retire_valid <= pop;
      retire_we    <= pop && writes_rd;
    end
  end

  // Retire payload, meaningful only with retire_valid
  always_ff @(posedge clk) begin
    if (pop) begin
      retire_pc   <= head_pc;
      retire_rd   <= rd;
      retire_data <= result;
    end
  end

endmodule

`default_nettype wire

// File: design/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_defs.svh"

module fetch_unit (
  input  wire                       clk,
  input  wire                       reset,
  input  wire  rv_core_pkg::xlen_t  entry,       // Start address after reset
  input  wire                       imem_ack,
  input  wire  rv_core_pkg::inst_t  imem_data,
  input  wire                       full,        // Queue back-pressure
  input  wire                       redirect,
  input  wire  rv_core_pkg::xlen_t  redirect_pc,
  output logic                      imem_req,
  output rv_core_pkg::xlen_t        imem_addr,
  output logic                      push,
  output rv_core_pkg::xlen_t        push_pc,
  output rv_core_pkg::inst_t        push_inst
);

  localparam int unsigned inst_bytes = `RV_ILEN / 8;

  rv_core_pkg::fetch_state_t state;
  rv_core_pkg::xlen_t        pc;      // Address of the next request
  logic                      issue;   // Open a new handshake
  logic                      capture; // Take the returned word into the queue

  // New request only once memory has let go of ack
  assign issue   = (state == rv_core_pkg::FETCH_IDLE) && !redirect && !imem_ack;
  // Stall on full, ack stays high and data stays valid meanwhile
  assign capture = (state == rv_core_pkg::FETCH_WAIT_ACK) && imem_ack && !full && !redirect;

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= rv_core_pkg::FETCH_IDLE;
      pc       <= entry;
      imem_req <= 1'b0;
      push     <= 1'b0;
    end else begin
      push <= 1'b0; // One cycle pulse per captured word
      case (state)
        rv_core_pkg::FETCH_IDLE: begin
          if (redirect) begin
            pc <= redirect_pc; // Request the target next
          end else if (issue) begin
            imem_req <= 1'b1;
            state    <= rv_core_pkg::FETCH_WAIT_ACK;
          end
        end
        rv_core_pkg::FETCH_WAIT_ACK: begin
          if (redirect) begin
            pc <= redirect_pc;
            // In-flight word is wrong path
            if (imem_ack) begin
              imem_req <= 1'b0; // Close now and drop the word
              state    <= rv_core_pkg::FETCH_IDLE;
            end else begin
              state <= rv_core_pkg::FETCH_WAIT_DROP;
            end
          end else if (capture) begin
            imem_req <= 1'b0;
            push     <= 1'b1;
            pc       <= pc + rv_core_pkg::xlen_t'(inst_bytes);
            state    <= rv_core_pkg::FETCH_IDLE;
          end
        end
        rv_core_pkg::FETCH_WAIT_DROP: begin
          if (redirect) begin
            pc <= redirect_pc; // Latest target wins
          end
          if (imem_ack) begin
            imem_req <= 1'b0; // Finish handshake, discard data
            state    <= rv_core_pkg::FETCH_IDLE;
          end
        end
        default: begin
          imem_req <= 1'b0;
          state    <= rv_core_pkg::FETCH_IDLE;
        end
      endcase
    end
  end

  // Address and captured word
  always_ff @(posedge clk) begin
    if (issue) begin
      imem_addr <= pc; // Held stable for the whole handshake
    end
    if (capture) begin
      push_pc   <= imem_addr;
      push_inst <= imem_data;
    end
  end

endmodule

`default_nettype wire

// File: design/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_defs.svh"

module inst_decoder (
  input  wire  rv_core_pkg::inst_t  inst,
  output rv_core_pkg::op_kind_t     op,
  output rv_core_pkg::reg_addr_t    rd,
  output rv_core_pkg::reg_addr_t    rs1,
  output rv_core_pkg::reg_addr_t    rs2,
  output rv_core_pkg::xlen_t        imm,
  output logic                      writes_rd
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // Fixed field positions in every format
  assign rd  = inst[11:7];
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];

  always_comb begin
    op = rv_core_pkg::OP_NOP;
    case (opcode)
      `RV_OP_IMM: begin
        if (funct3 == 3'b000) op = rv_core_pkg::OP_ADDI;
      end
      `RV_OP_REG: begin
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  op = rv_core_pkg::OP_ADD;
            3'b100:  op = rv_core_pkg::OP_XOR;
            3'b110:  op = rv_core_pkg::OP_OR;
            3'b111:  op = rv_core_pkg::OP_AND;
            default: op = rv_core_pkg::OP_NOP; // Shifts, compares
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          op = rv_core_pkg::OP_SUB;
        end
      end
      `RV_OP_LUI: op = rv_core_pkg::OP_LUI;
      `RV_OP_JAL: op = rv_core_pkg::OP_JAL;
      `RV_OP_JALR: begin
        if (funct3 == 3'b000) op = rv_core_pkg::OP_JALR;
      end
      default: op = rv_core_pkg::OP_NOP;
    endcase
  end

  // Sign-extended immediate by format
  always_comb begin
    case (opcode)
      `RV_OP_LUI: imm = {{(`RV_XLEN-32){inst[31]}}, inst[31:12], 12'b0};
      `RV_OP_JAL: imm = {{(`RV_XLEN-21){inst[31]}}, inst[31], inst[19:12],
                         inst[20], inst[30:21], 1'b0};
      default:    imm = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]}; // I-type
    endcase
  end

  // x0 destination is a discard
  assign writes_rd = (op != rv_core_pkg::OP_NOP) && (rd != '0);

endmodule

`default_nettype wire

// File: design/inst_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_defs.svh"

module inst_queue #(
  parameter int depth = `RV_QUEUE_DEPTH // Power of two
) (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       push,
  input  wire  rv_core_pkg::xlen_t  push_pc,
  input  wire  rv_core_pkg::inst_t  push_inst,
  input  wire                       pop,
  input  wire                       flush,     // Drop everything, push included
  output rv_core_pkg::xlen_t        head_pc,
  output rv_core_pkg::inst_t        head_inst,
  output logic                      empty,
  output logic                      full
);

  localparam int ptr_w = $clog2(depth);

  rv_core_pkg::xlen_t pc_mem   [depth];
  rv_core_pkg::inst_t inst_mem [depth];

  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0]   count;   // One extra bit to tell full from empty
  logic             do_push;
  logic             do_pop;

  assign empty   = (count == '0);
  assign full    = (count == (ptr_w+1)'(depth));
  assign do_push = push && !full && !flush;
  assign do_pop  = pop && !empty && !flush;

  assign head_pc   = pc_mem[rd_ptr];
  assign head_inst = inst_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1; // Wraps at depth
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      count <= count + (ptr_w+1)'(do_push) - (ptr_w+1)'(do_pop);
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      pc_mem[wr_ptr]   <= push_pc;
      inst_mem[wr_ptr] <= push_inst;
    end
  end

endmodule

`default_nettype wire

// File: design/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_defs.svh"

module register_file (
  input  wire                          clk,
  input  wire                          reset,
  input  wire  rv_core_pkg::xlen_t     stackptr,     // Initial sp
  input  wire  rv_core_pkg::reg_addr_t rs1,
  input  wire  rv_core_pkg::reg_addr_t rs2,
  input  wire                          write_enable,
  input  wire  rv_core_pkg::reg_addr_t write_addr,
  input  wire  rv_core_pkg::xlen_t     write_data,
  output rv_core_pkg::xlen_t           read_data1,
  output rv_core_pkg::xlen_t           read_data2
);

  rv_core_pkg::xlen_t regs [`RV_NREGS];

  // Async reads, x0 reads zero since it is never written
  assign read_data1 = regs[rs1];
  assign read_data2 = regs[rs2];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= (i == 2) ? stackptr : '0; // x2 is sp
      end
    end else if (write_enable && write_addr != '0) begin
      regs[write_addr] <= write_data;
    end
  end

endmodule

`default_nettype wire

// File: design/rv_core_defs.svh
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// Datapath and address width
`define RV_XLEN 64

// Instruction word width
`define RV_ILEN 32

// Architectural registers x0..x31
`define RV_NREGS 32

// Fetch to execute buffering, power of two
`define RV_QUEUE_DEPTH 4

// Major opcodes, bits [6:0]
`define RV_OP_IMM  7'b0010011 // ADDI family
`define RV_OP_REG  7'b0110011 // ADD, SUB, AND, OR, XOR
`define RV_OP_LUI  7'b0110111
`define RV_OP_JAL  7'b1101111
`define RV_OP_JALR 7'b1100111

`endif

// File: design/rv_core_pkg.sv
`default_nettype none

`include "rv_core_defs.svh"

package rv_core_pkg;

  // Data word or byte address
  typedef logic [`RV_XLEN-1:0] xlen_t;

  // Raw instruction word
  typedef logic [`RV_ILEN-1:0] inst_t;

  // Register index
  typedef logic [$clog2(`RV_NREGS)-1:0] reg_addr_t;

  // Decoded operation
  typedef enum logic [3:0] {
    OP_ADDI,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_LUI,
    OP_JAL,
    OP_JALR,
    OP_NOP    // Anything not supported, retires without a write
  } op_kind_t;

  // Instruction port handshake states
  typedef enum logic [1:0] {
    FETCH_IDLE,      // req low, waiting for ack to fall
    FETCH_WAIT_ACK,  // req high, response wanted
    FETCH_WAIT_DROP  // req high, response to be thrown away
  } fetch_state_t;

endpackage

`default_nettype wire

// File: design/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
  input  wire                       clk,
  input  wire                       reset,
  input  wire  rv_core_pkg::xlen_t  entry,      // Program entry point
  input  wire  rv_core_pkg::xlen_t  stackptr,   // Initial x2
  input  wire                       imem_ack,
  input  wire  rv_core_pkg::inst_t  imem_data,
  output logic                      imem_req,
  output rv_core_pkg::xlen_t        imem_addr,
  output logic                      retire_valid,
  output rv_core_pkg::xlen_t        retire_pc,
  output rv_core_pkg::reg_addr_t    retire_rd,
  output rv_core_pkg::xlen_t        retire_data,
  output logic                      retire_we
);

  logic               push;
  logic               pop;
  logic               full;
  logic               empty;
  logic               redirect;    // Also flushes the queue
  rv_core_pkg::xlen_t push_pc;
  rv_core_pkg::inst_t push_inst;
  rv_core_pkg::xlen_t head_pc;
  rv_core_pkg::inst_t head_inst;
  rv_core_pkg::xlen_t redirect_pc;

  fetch_unit u_fetch (
    .clk         (clk),
    .reset       (reset),
    .entry       (entry),
    .imem_ack    (imem_ack),
    .imem_data   (imem_data),
    .full        (full),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .imem_req    (imem_req),
    .imem_addr   (imem_addr),
    .push        (push),
    .push_pc     (push_pc),
    .push_inst   (push_inst)
  );

  inst_queue u_queue (
    .clk       (clk),
    .reset     (reset),
    .push      (push),
    .push_pc   (push_pc),
    .push_inst (push_inst),
    .pop       (pop),
    .flush     (redirect),
    .head_pc   (head_pc),
    .head_inst (head_inst),
    .empty     (empty),
    .full      (full)
  );

  execute_unit u_execute (
    .clk          (clk),
    .reset        (reset),
    .stackptr     (stackptr),
    .head_pc      (head_pc),
    .head_inst    (head_inst),
    .empty        (empty),
    .pop          (pop),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .retire_we    (retire_we)
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --top-module tb_rv_core_top -f rv_core_top.f; then
  echo "Verilator build failed"
  exit 1
fi

# Output kept in memory only
if ! output=$(./obj_dir/Vtb_rv_core_top); then
  printf '%s\n' "$output"
  echo "Simulation exited with an error"
  exit 1
fi
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1

// File: rv_core_top.f
+incdir+design
+incdir+bench
design/rv_core_pkg.sv
design/fetch_unit.sv
design/inst_queue.sv
design/inst_decoder.sv
design/register_file.sv
design/execute_unit.sv
design/rv_core_top.sv
bench/tb_rv_core_top.sv
